/* verilog/hart_defs.svh */
`ifndef HART_DEFS_SVH
`define HART_DEFS_SVH

// Datapath and register address widths
`define HART_XLEN        32
`define HART_REG_AW      5
// First fetch address out of reset
`define HART_RESET_ADDR  32'h0000_0000

// Major opcodes handled by decode
`define HART_OP_OP       7'b0110011
`define HART_OP_OP_IMM   7'b0010011
`define HART_OP_LUI      7'b0110111
`define HART_OP_AUIPC    7'b0010111
`define HART_OP_LOAD     7'b0000011
`define HART_OP_STORE    7'b0100011
`define HART_OP_SYSTEM   7'b1110011

// Memory access size in funct3
`define HART_F3_BYTE     3'b000
`define HART_F3_HALF     3'b001
`define HART_F3_WORD     3'b010
`define HART_F3_BYTE_U   3'b100
`define HART_F3_HALF_U   3'b101

// ALU select codes
`define HART_ALU_W       4
`define HART_ALU_ADD     4'd0
`define HART_ALU_SUB     4'd1
`define HART_ALU_SLL     4'd2
`define HART_ALU_SLT     4'd3
`define HART_ALU_SLTU    4'd4
`define HART_ALU_XOR     4'd5
`define HART_ALU_SRL     4'd6
`define HART_ALU_SRA     4'd7
`define HART_ALU_OR      4'd8
`define HART_ALU_AND     4'd9

`endif

/* verilog/hart_pkg.sv */
`include "hart_defs.svh"

package hart_pkg;

    //////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]              funct7;
        logic [`HART_REG_AW-1:0] rs2;
        logic [`HART_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`HART_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]             imm;
        logic [`HART_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`HART_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]              imm_hi;
        logic [`HART_REG_AW-1:0] rs2;
        logic [`HART_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [4:0]              imm_lo;
        logic [6:0]              opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]             imm;
        logic [`HART_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } u_fmt_t;

    // One fetched word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_u;

    //////////////////////////////////////////////////
    // Pipeline registers
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`HART_XLEN-1:0]   pc;
        logic [`HART_XLEN-1:0]   inst;
        logic [`HART_REG_AW-1:0] rs1_raddr;
        logic [`HART_REG_AW-1:0] rs2_raddr;
        logic [`HART_XLEN-1:0]   rs1_rdata;
        logic [`HART_XLEN-1:0]   rs2_rdata;
        logic [`HART_XLEN-1:0]   imm;
        logic [`HART_REG_AW-1:0] rd_waddr;
        logic [`HART_ALU_W-1:0]  alu_sel;
        // Operand one from pc or from zero, operand two from imm
        logic                    op1_pc;
        logic                    op1_zero;
        logic                    op2_imm;
        logic                    load;
        logic                    store;
        logic                    reg_write;
        logic                    mem_to_reg;
        logic                    halt;
        logic                    valid;
    } id_ex_t;

    typedef struct packed {
        logic [`HART_XLEN-1:0]   pc;
        logic [`HART_XLEN-1:0]   inst;
        logic [`HART_REG_AW-1:0] rs1_raddr;
        logic [`HART_REG_AW-1:0] rs2_raddr;
        // Store data
        logic [`HART_XLEN-1:0]   rs2_rdata;
        logic [`HART_REG_AW-1:0] rd_waddr;
        logic [`HART_XLEN-1:0]   alu_result;
        logic                    load;
        logic                    store;
        logic                    reg_write;
        logic                    mem_to_reg;
        logic                    halt;
        logic                    valid;
    } ex_mem_t;

    typedef struct packed {
        logic [`HART_XLEN-1:0]   pc;
        logic [`HART_XLEN-1:0]   inst;
        logic [`HART_REG_AW-1:0] rs1_raddr;
        logic [`HART_REG_AW-1:0] rs2_raddr;
        logic [`HART_REG_AW-1:0] rd_waddr;
        logic [`HART_XLEN-1:0]   alu_result;
        // Byte offset and size, kept for load extraction
        logic [1:0]              offset;
        logic [2:0]              funct3;
        logic                    reg_write;
        logic                    mem_to_reg;
        logic                    halt;
        logic                    valid;
    } mem_wb_t;

    //////////////////////////////////////////////////
    // External ports
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`HART_XLEN-1:0] addr;
        logic                  ren;
        logic                  wen;
        logic [3:0]            mask;
        logic [`HART_XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`HART_XLEN-1:0]   inst;
        logic                    halt;
        logic [`HART_XLEN-1:0]   pc;
        logic [`HART_REG_AW-1:0] rs1_raddr;
        logic [`HART_REG_AW-1:0] rs2_raddr;
        logic [`HART_REG_AW-1:0] rd_waddr;
        logic [`HART_XLEN-1:0]   rd_wdata;
    } retire_t;

endpackage

/* verilog/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hart_defs.svh"

module reg_file (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [`HART_REG_AW-1:0] i_rs1_raddr,
    input  logic [`HART_REG_AW-1:0] i_rs2_raddr,
    input  logic                    i_rd_wen,
    input  logic [`HART_REG_AW-1:0] i_rd_waddr,
    input  logic [`HART_XLEN-1:0]   i_rd_wdata,
    output logic [`HART_XLEN-1:0]   o_rs1_rdata,
    output logic [`HART_XLEN-1:0]   o_rs2_rdata
);

    // x1..x31 only, x0 has no storage
    logic [`HART_XLEN-1:0] regs [1:31];

    // Read with x0 as zero and writeback bypass
    function automatic logic [`HART_XLEN-1:0] read_port(input logic [`HART_REG_AW-1:0] raddr);
        logic [`HART_XLEN-1:0] rdata;
        if (raddr == '0) begin
            rdata = '0;
        end else if (i_rd_wen && (i_rd_waddr == raddr)) begin
            rdata = i_rd_wdata;
        end else begin
            rdata = regs[raddr];
        end
        return rdata;
    endfunction

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_waddr != '0)) begin
            // Writes to x0 are dropped here
            regs[i_rd_waddr] <= i_rd_wdata;
        end
    end

    always_comb begin
        o_rs1_rdata = read_port(i_rs1_raddr);
        o_rs2_rdata = read_port(i_rs2_raddr);
    end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hart_defs.svh"

module decode_stage (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  logic [`HART_XLEN-1:0]   i_pc,
    input  hart_pkg::inst_u         i_inst,
    input  logic [`HART_XLEN-1:0]   i_rs1_rdata,
    input  logic [`HART_XLEN-1:0]   i_rs2_rdata,
    output logic [`HART_REG_AW-1:0] o_rs1_raddr,
    output logic [`HART_REG_AW-1:0] o_rs2_raddr,
    output hart_pkg::id_ex_t        o_id_ex
);

    hart_pkg::id_ex_t id_ex_d;
    logic             use_rs1;
    logic             use_rs2;

    // funct3 to ALU select, alt picks sub or sra
    function automatic logic [`HART_ALU_W-1:0] alu_sel(input logic [2:0] funct3,
                                                       input logic       alt);
        logic [`HART_ALU_W-1:0] sel;
        case (funct3)
            3'b000:  sel = alt ? `HART_ALU_SUB : `HART_ALU_ADD;
            3'b001:  sel = `HART_ALU_SLL;
            3'b010:  sel = `HART_ALU_SLT;
            3'b011:  sel = `HART_ALU_SLTU;
            3'b100:  sel = `HART_ALU_XOR;
            3'b101:  sel = alt ? `HART_ALU_SRA : `HART_ALU_SRL;
            3'b110:  sel = `HART_ALU_OR;
            default: sel = `HART_ALU_AND;
        endcase
        return sel;
    endfunction

    //////////////////////////////////////////////////
    // Control and immediate decode
    //////////////////////////////////////////////////

    always_comb begin
        id_ex_d = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        id_ex_d.alu_sel = `HART_ALU_ADD;
        case (i_inst.r.opcode)
            `HART_OP_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_sel = alu_sel(i_inst.r.funct3, i_inst.r.funct7[5]);
            end
            `HART_OP_OP_IMM: begin
                use_rs1 = 1'b1;
                id_ex_d.op2_imm = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
                // Bit 30 is immediate data except for srai
                id_ex_d.alu_sel = alu_sel(i_inst.r.funct3,
                                          (i_inst.r.funct3 == 3'b101) && i_inst.r.funct7[5]);
            end
            `HART_OP_LUI: begin
                id_ex_d.op1_zero = 1'b1;
                id_ex_d.op2_imm = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm = {i_inst.u.imm, 12'b0};
            end
            `HART_OP_AUIPC: begin
                id_ex_d.op1_pc = 1'b1;
                id_ex_d.op2_imm = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm = {i_inst.u.imm, 12'b0};
            end
            `HART_OP_LOAD: begin
                use_rs1 = 1'b1;
                id_ex_d.op2_imm = 1'b1;
                id_ex_d.load = 1'b1;
                id_ex_d.mem_to_reg = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.imm = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
            end
            `HART_OP_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                id_ex_d.op2_imm = 1'b1;
                id_ex_d.store = 1'b1;
                id_ex_d.imm = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
            end
            `HART_OP_SYSTEM: begin
                // Only ebreak is recognized
                id_ex_d.halt = (i_inst.i.imm == 12'h001);
            end
            default: ;
        endcase
        // Unused sources read as x0
        o_rs1_raddr = use_rs1 ? i_inst.r.rs1 : '0;
        o_rs2_raddr = use_rs2 ? i_inst.r.rs2 : '0;
        id_ex_d.pc = i_pc;
        id_ex_d.inst = i_inst;
        id_ex_d.rs1_raddr = o_rs1_raddr;
        id_ex_d.rs2_raddr = o_rs2_raddr;
        id_ex_d.rs1_rdata = i_rs1_rdata;
        id_ex_d.rs2_rdata = i_rs2_rdata;
        id_ex_d.rd_waddr = i_inst.r.rd;
        id_ex_d.valid = i_valid;
    end

    // ID/EX register
    always_ff @(posedge i_clk) begin
        o_id_ex <= id_ex_d;
        if (!i_rst_n) begin
            o_id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hart_defs.svh"

module execute_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  hart_pkg::id_ex_t  i_id_ex,
    output hart_pkg::ex_mem_t o_ex_mem
);

    hart_pkg::ex_mem_t     ex_mem_d;
    logic [`HART_XLEN-1:0] op1;
    logic [`HART_XLEN-1:0] op2;
    logic [`HART_XLEN-1:0] result;

    always_comb begin
        // Zero for lui, pc for auipc
        op1 = i_id_ex.op1_zero ? '0 : (i_id_ex.op1_pc ? i_id_ex.pc : i_id_ex.rs1_rdata);
        op2 = i_id_ex.op2_imm ? i_id_ex.imm : i_id_ex.rs2_rdata;
        case (i_id_ex.alu_sel)
            `HART_ALU_ADD:  result = op1 + op2;
            `HART_ALU_SUB:  result = op1 - op2;
            `HART_ALU_SLL:  result = op1 << op2[4:0];
            `HART_ALU_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
            `HART_ALU_SLTU: result = {31'b0, op1 < op2};
            `HART_ALU_XOR:  result = op1 ^ op2;
            `HART_ALU_SRL:  result = op1 >> op2[4:0];
            `HART_ALU_SRA:  result = $signed(op1) >>> op2[4:0];
            `HART_ALU_OR:   result = op1 | op2;
            default:        result = op1 & op2;
        endcase
    end

    // Carry control and addresses along with the result
    always_comb begin
        ex_mem_d.pc = i_id_ex.pc;
        ex_mem_d.inst = i_id_ex.inst;
        ex_mem_d.rs1_raddr = i_id_ex.rs1_raddr;
        ex_mem_d.rs2_raddr = i_id_ex.rs2_raddr;
        ex_mem_d.rs2_rdata = i_id_ex.rs2_rdata;
        ex_mem_d.rd_waddr = i_id_ex.rd_waddr;
        ex_mem_d.alu_result = result;
        ex_mem_d.load = i_id_ex.load;
        ex_mem_d.store = i_id_ex.store;
        ex_mem_d.reg_write = i_id_ex.reg_write;
        ex_mem_d.mem_to_reg = i_id_ex.mem_to_reg;
        ex_mem_d.halt = i_id_ex.halt;
        ex_mem_d.valid = i_id_ex.valid;
    end

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        o_ex_mem <= ex_mem_d;
        if (!i_rst_n) begin
            o_ex_mem.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hart_defs.svh"

module mem_stage (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  hart_pkg::ex_mem_t     i_ex_mem,
    input  logic [`HART_XLEN-1:0] i_dmem_rdata,
    output hart_pkg::dmem_req_t   o_dmem,
    output hart_pkg::mem_wb_t     o_mem_wb,
    output logic [`HART_XLEN-1:0] o_load_data
);

    hart_pkg::mem_wb_t     mem_wb_d;
    logic [1:0]            offset;
    logic [2:0]            funct3;
    logic [`HART_XLEN-1:0] byte_lane;
    logic [`HART_XLEN-1:0] half_lane;

    //////////////////////////////////////////////////
    // Request toward data memory
    //////////////////////////////////////////////////

    always_comb begin
        offset = i_ex_mem.alu_result[1:0];
        funct3 = i_ex_mem.inst[14:12];
        o_dmem.addr = {i_ex_mem.alu_result[`HART_XLEN-1:2], 2'b00};
        o_dmem.ren = i_ex_mem.valid && i_ex_mem.load;
        o_dmem.wen = i_ex_mem.valid && i_ex_mem.store;
        o_dmem.mask = 4'b1111;
        o_dmem.wdata = i_ex_mem.rs2_rdata;
        // Non-memory instructions keep all four lanes
        if (i_ex_mem.load || i_ex_mem.store) begin
            case (funct3)
                `HART_F3_BYTE, `HART_F3_BYTE_U: begin
                    o_dmem.mask = 4'b0001 << offset;
                    o_dmem.wdata = i_ex_mem.rs2_rdata << {offset, 3'b000};
                end
                `HART_F3_HALF, `HART_F3_HALF_U: begin
                    o_dmem.mask = offset[1] ? 4'b1100 : 4'b0011;
                    o_dmem.wdata = i_ex_mem.rs2_rdata << {offset[1], 4'b0000};
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        mem_wb_d.pc = i_ex_mem.pc;
        mem_wb_d.inst = i_ex_mem.inst;
        mem_wb_d.rs1_raddr = i_ex_mem.rs1_raddr;
        mem_wb_d.rs2_raddr = i_ex_mem.rs2_raddr;
        mem_wb_d.rd_waddr = i_ex_mem.rd_waddr;
        mem_wb_d.alu_result = i_ex_mem.alu_result;
        mem_wb_d.offset = offset;
        mem_wb_d.funct3 = funct3;
        mem_wb_d.reg_write = i_ex_mem.reg_write;
        mem_wb_d.mem_to_reg = i_ex_mem.mem_to_reg;
        mem_wb_d.halt = i_ex_mem.halt;
        mem_wb_d.valid = i_ex_mem.valid;
    end

    // MEM/WB register
    always_ff @(posedge i_clk) begin
        o_mem_wb <= mem_wb_d;
        if (!i_rst_n) begin
            o_mem_wb.valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Load extraction, one cycle after the request
    //////////////////////////////////////////////////

    always_comb begin
        // Addressed lane moved down to bit 0
        byte_lane = i_dmem_rdata >> {o_mem_wb.offset, 3'b000};
        half_lane = i_dmem_rdata >> {o_mem_wb.offset[1], 4'b0000};
        case (o_mem_wb.funct3)
            `HART_F3_BYTE:   o_load_data = {{(`HART_XLEN-8){byte_lane[7]}}, byte_lane[7:0]};
            `HART_F3_BYTE_U: o_load_data = {{(`HART_XLEN-8){1'b0}}, byte_lane[7:0]};
            `HART_F3_HALF:   o_load_data = {{(`HART_XLEN-16){half_lane[15]}}, half_lane[15:0]};
            `HART_F3_HALF_U: o_load_data = {{(`HART_XLEN-16){1'b0}}, half_lane[15:0]};
            `HART_F3_WORD:   o_load_data = i_dmem_rdata;
            default:         o_load_data = i_dmem_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/hart.sv */
`timescale 1ns/1ns
`default_nettype none
`include "hart_defs.svh"

module hart (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [`HART_XLEN-1:0] i_imem_rdata,
    input  logic [`HART_XLEN-1:0] i_dmem_rdata,
    output logic [`HART_XLEN-1:0] o_imem_raddr,
    output hart_pkg::dmem_req_t   o_dmem,
    output hart_pkg::retire_t     o_retire
);

    logic [`HART_XLEN-1:0]   pc_q;
    logic [`HART_XLEN-1:0]   f_pc_q;
    logic                    f_valid_q;
    logic                    halted_q;
    hart_pkg::inst_u         f_inst;
    logic [`HART_REG_AW-1:0] rs1_raddr;
    logic [`HART_REG_AW-1:0] rs2_raddr;
    logic [`HART_XLEN-1:0]   rs1_rdata;
    logic [`HART_XLEN-1:0]   rs2_rdata;
    hart_pkg::id_ex_t        id_ex;
    hart_pkg::ex_mem_t       ex_mem;
    hart_pkg::mem_wb_t       mem_wb;
    logic [`HART_XLEN-1:0]   load_data;
    logic [`HART_XLEN-1:0]   wb_data;
    logic                    wb_wen;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////

    // PC freezes and fetch stops once ebreak retires
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= `HART_RESET_ADDR;
            f_valid_q <= 1'b0;
            halted_q <= 1'b0;
        end else begin
            if (!halted_q) begin
                pc_q <= pc_q + 32'd4;
            end
            f_valid_q <= !halted_q;
            if (mem_wb.valid && mem_wb.halt) begin
                halted_q <= 1'b1;
            end
        end
    end

    // pc lined up with the synchronous imem word
    always_ff @(posedge i_clk) begin
        f_pc_q <= pc_q;
    end

    assign o_imem_raddr = pc_q;
    assign f_inst = i_imem_rdata;

    reg_file reg_file_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rs1_raddr (rs1_raddr),
        .i_rs2_raddr (rs2_raddr),
        .i_rd_wen    (wb_wen),
        .i_rd_waddr  (mem_wb.rd_waddr),
        .i_rd_wdata  (wb_data),
        .o_rs1_rdata (rs1_rdata),
        .o_rs2_rdata (rs2_rdata)
    );

    decode_stage decode_stage_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (f_valid_q),
        .i_pc        (f_pc_q),
        .i_inst      (f_inst),
        .i_rs1_rdata (rs1_rdata),
        .i_rs2_rdata (rs2_rdata),
        .o_rs1_raddr (rs1_raddr),
        .o_rs2_raddr (rs2_raddr),
        .o_id_ex     (id_ex)
    );

    execute_stage execute_stage_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_id_ex  (id_ex),
        .o_ex_mem (ex_mem)
    );

    mem_stage mem_stage_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ex_mem     (ex_mem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem       (o_dmem),
        .o_mem_wb     (mem_wb),
        .o_load_data  (load_data)
    );

    //////////////////////////////////////////////////
    // Writeback and retire
    //////////////////////////////////////////////////

    // Instructions still in flight behind ebreak are squashed
    assign wb_data = mem_wb.mem_to_reg ? load_data : mem_wb.alu_result;
    assign wb_wen = mem_wb.valid && mem_wb.reg_write && !halted_q;

    always_comb begin
        o_retire.valid = mem_wb.valid && !halted_q;
        o_retire.inst = mem_wb.inst;
        o_retire.halt = mem_wb.halt;
        o_retire.pc = mem_wb.pc;
        o_retire.rs1_raddr = mem_wb.rs1_raddr;
        o_retire.rs2_raddr = mem_wb.rs2_raddr;
        o_retire.rd_waddr = mem_wb.reg_write ? mem_wb.rd_waddr : '0;
        o_retire.rd_wdata = wb_data;
    end

endmodule

`default_nettype wire

/* verification/hart_tb.sv */
`timescale 1ns/1ns

module hart_tb;

    localparam int REC_MAX = 64;
    localparam int REC_W = 5;

    // Record kinds in the test data
    localparam logic [31:0] K_ALU = 32'd0;
    localparam logic [31:0] K_LOAD = 32'd1;
    localparam logic [31:0] K_STORE = 32'd2;
    localparam logic [31:0] K_X0 = 32'd3;
    localparam logic [31:0] K_HALT = 32'd4;

    logic                i_clk;
    logic                i_rst_n;
    logic [31:0]         i_imem_rdata;
    logic [31:0]         i_dmem_rdata;
    logic [31:0]         o_imem_raddr;
    hart_pkg::dmem_req_t o_dmem;
    hart_pkg::retire_t   o_retire;

    logic [31:0] tdata [0:REC_MAX*REC_W-1];
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] dmem_init [0:255];
    logic [31:0] imem_addr_q;
    logic [31:0] dmem_addr_q;
    logic        dmem_ren_q;
    integer      seed;
    int          prog_len;
    int          n_checks;
    int          n_errors;
    bit          halt_seen;

    hart dut_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_imem_rdata (i_imem_rdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_raddr (o_imem_raddr),
        .o_dmem       (o_dmem),
        .o_retire     (o_retire)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////

    // Read data one cycle after the address, all driven on the falling edge
    always @(negedge i_clk) begin
        i_imem_rdata <= imem[imem_addr_q[9:2]];
        // Data word only comes back for a read request
        i_dmem_rdata <= dmem_ren_q ? dmem[dmem_addr_q[9:2]] : '0;
        imem_addr_q <= o_imem_raddr;
        dmem_addr_q <= o_dmem.addr;
        dmem_ren_q <= (o_dmem.ren === 1'b1);
        if (o_dmem.wen === 1'b1) begin
            for (int b = 0; b < 4; b++) begin
                if (o_dmem.mask[b]) begin
                    dmem[o_dmem.addr[9:2]][8*b +: 8] = o_dmem.wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s is %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] kind_of(input int rec);
        return tdata[rec*REC_W + 1];
    endfunction

    function automatic string test_name(input logic [31:0] kind);
        case (kind)
            K_ALU:   return "alu and upper immediate";
            K_LOAD:  return "loads";
            K_STORE: return "stores";
            K_X0:    return "x0 write";
            default: return "ebreak";
        endcase
    endfunction

    // Lane select and extension from the untouched initial data word
    function automatic logic [31:0] load_expect(input logic [31:0] addr,
                                                input logic [2:0] funct3);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = dmem_init[addr[9:2]];
        b = word[8*addr[1:0] +: 8];
        h = word[16*addr[1] +: 16];
        case (funct3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'h0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // rs1 is read by register, immediate, load and store formats
    function automatic logic [31:0] rs1_expect(input logic [31:0] inst);
        case (inst[6:0])
            7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011: return 32'(inst[19:15]);
            default: return 32'h0;
        endcase
    endfunction

    // rs2 only for register-register and stores
    function automatic logic [31:0] rs2_expect(input logic [31:0] inst);
        case (inst[6:0])
            7'b0110011, 7'b0100011: return 32'(inst[24:20]);
            default: return 32'h0;
        endcase
    endfunction

    // Idle outputs during reset and pipeline fill
    task automatic check_idle();
        check_value("o_retire.valid", 32'(o_retire.valid), 32'h0);
        check_value("o_dmem.ren", 32'(o_dmem.ren), 32'h0);
        check_value("o_dmem.wen", 32'(o_dmem.wen), 32'h0);
    endtask

    // Store request against the next store record
    task automatic check_store(inout int st_rec);
        while (st_rec < prog_len && kind_of(st_rec) != K_STORE) begin
            st_rec++;
        end
        if (st_rec >= prog_len) begin
            n_errors++;
            $display("Store request at %0t matches no store in the program", $time);
        end else begin
            check_value("o_dmem.addr", o_dmem.addr, tdata[st_rec*REC_W + 2]);
            check_value("o_dmem.mask", 32'(o_dmem.mask), tdata[st_rec*REC_W + 3]);
            check_value("o_dmem.wdata", o_dmem.wdata, tdata[st_rec*REC_W + 4]);
            check_value("o_dmem.ren", 32'(o_dmem.ren), 32'h0);
            st_rec++;
        end
    endtask

    // One retire against its record
    task automatic check_retire(input int rec);
        logic [31:0] inst;
        logic [31:0] kind;
        logic [31:0] val;
        inst = tdata[rec*REC_W];
        kind = tdata[rec*REC_W + 1];
        val = tdata[rec*REC_W + 2];
        check_value("o_retire.pc", o_retire.pc, 32'(rec * 4));
        check_value("o_retire.inst", o_retire.inst, inst);
        check_value("o_retire.halt", 32'(o_retire.halt), 32'(kind == K_HALT));
        check_value("o_retire.rs1_raddr", 32'(o_retire.rs1_raddr), rs1_expect(inst));
        check_value("o_retire.rs2_raddr", 32'(o_retire.rs2_raddr), rs2_expect(inst));
        case (kind)
            K_ALU: begin
                check_value("o_retire.rd_waddr", 32'(o_retire.rd_waddr), 32'(inst[11:7]));
                check_value("o_retire.rd_wdata", o_retire.rd_wdata, val);
            end
            K_LOAD: begin
                check_value("o_retire.rd_waddr", 32'(o_retire.rd_waddr), 32'(inst[11:7]));
                check_value("o_retire.rd_wdata", o_retire.rd_wdata,
                            load_expect(val, inst[14:12]));
            end
            K_X0: begin
                check_value("o_retire.rd_waddr", 32'(o_retire.rd_waddr), 32'h0);
                check_value("o_retire.rd_wdata", o_retire.rd_wdata, val);
            end
            default: begin
                check_value("o_retire.rd_waddr", 32'(o_retire.rd_waddr), 32'h0);
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int rec;
        int st_rec;
        int st_cnt;
        int n_stores;
        int cyc;
        int grp_err;
        i_rst_n = 1'b0;
        i_imem_rdata = '0;
        i_dmem_rdata = '0;
        imem_addr_q = '0;
        dmem_addr_q = '0;
        dmem_ren_q = 1'b0;
        n_checks = 0;
        n_errors = 0;
        halt_seen = 1'b0;
        seed = 14557;
        rec = 0;
        st_rec = 0;
        st_cnt = 0;
        n_stores = 0;
        cyc = 0;
        $readmemh("verification/hart_testdata.txt", tdata);
        prog_len = 0;
        while (prog_len < REC_MAX && kind_of(prog_len) !== K_HALT) begin
            prog_len++;
        end
        prog_len++;
        // Program first, the rest padded with addi x0 carrying the index
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_len) ? tdata[i*REC_W] : {i[11:0], 20'h00013};
            dmem[i] = $random(seed);
            dmem_init[i] = dmem[i];
            if (i < prog_len && kind_of(i) == K_STORE) begin
                n_stores++;
            end
        end
        repeat (3) begin
            @(negedge i_clk);
            check_idle();
        end
        i_rst_n = 1'b1;
        $display("test reset finished: %0d errors", n_errors);
        grp_err = n_errors;
        while (!halt_seen) begin
            @(negedge i_clk);
            #1;
            cyc++;
            if (cyc < 4) begin
                check_idle();
            end else begin
                // One retire per cycle once the pipeline is full
                check_value("o_retire.valid", 32'(o_retire.valid), 32'h1);
            end
            if (o_dmem.wen === 1'b1) begin
                st_cnt++;
                check_store(st_rec);
            end
            if (o_retire.valid === 1'b1) begin
                if (rec >= prog_len) begin
                    n_errors++;
                    $display("Retire at %0t comes after the end of the program", $time);
                    halt_seen = 1'b1;
                end else begin
                    check_retire(rec);
                    halt_seen = (o_retire.halt === 1'b1);
                    // A test ends where the record kind changes
                    if (halt_seen || kind_of(rec + 1) !== kind_of(rec)) begin
                        // Every store record has had its request by its retire
                        if (kind_of(rec) == K_STORE) begin
                            check_value("store request count", st_cnt, n_stores);
                        end
                        $display("test %s finished: %0d errors", test_name(kind_of(rec)),
                                 n_errors - grp_err);
                        grp_err = n_errors;
                    end
                    rec++;
                end
            end
        end
        repeat (10) begin
            @(negedge i_clk);
            #1;
            check_value("o_retire.valid", 32'(o_retire.valid), 32'h0);
        end
        $display("test quiet after halt finished: %0d errors", n_errors - grp_err);
        $display("checks %0d, errors %0d, retired %0d of %0d", n_checks, n_errors, rec,
                 prog_len);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        @(posedge i_rst_n);
        #((prog_len + 20) * 8);
        $display("Timeout: the ebreak never retired within %0d cycles", prog_len + 20);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* verification/hart_testdata.txt */
// Columns: instruction, kind (0 alu, 1 load, 2 store, 3 x0 write, 4 ebreak),
// value (rd data, load byte address, or store word address), store mask, store data
12300093 0 00000123 0 0
FFB00113 0 FFFFFFFB 0 0
123451B7 0 12345000 0 0
00001217 0 0000100C 0 0
002082B3 0 0000011E 0 0
40208333 0 00000128 0 0
004173B3 0 00001008 0 0
0011E433 0 12345123 0 0
0021C4B3 0 EDCBAFFB 0 0
00209533 0 18000000 0 0
001155B3 0 1FFFFFFF 0 0
40115633 0 FFFFFFFF 0 0
001126B3 0 00000001 0 0
00113733 0 00000000 0 0
0F00C793 0 000001D3 0 0
7F017813 0 000007F0 0 0
00409893 0 00001230 0 0
01C15913 0 0000000F 0 0
40115993 0 FFFFFFFD 0 0
FFF0AA13 0 00000000 0 0
FFF0BA93 0 00000001 0 0
4000EB13 0 00000523 0 0
00708013 3 0000012A 0 0
04802023 2 00000040 F 12345123
04801323 2 00000044 C 51230000
04801423 2 00000048 3 12345123
048006A3 2 0000004C 2 34512300
048007A3 2 0000004C 8 23000000
04800623 2 0000004C 1 12345123
04800723 2 0000004C 4 51230000
00002B83 1 00000000 0 0
00500C03 1 00000005 0 0
00604C83 1 00000006 0 0
00700D03 1 00000007 0 0
00404D83 1 00000004 0 0
00801E03 1 00000008 0 0
00A05E83 1 0000000A 0 0
00E01F03 1 0000000E 0 0
00C05F83 1 0000000C 0 0
000000B3 0 00000000 0 0
00100073 4 00000000 0 0

/* src.f */
+incdir+verilog
verilog/hart_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/hart.sv
verification/hart_tb.sv

/* Bender.yml */
package:
  name: hart

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/hart_pkg.sv
      - verilog/reg_file.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/mem_stage.sv
      - verilog/hart.sv
  - target: test
    files:
      - verification/hart_tb.sv
